//--- testbench/mem_rd_cases.txt
# W <word address, hex> <data word, hex>
# R <controller, decimal> <word address, hex> <expected data word, hex>
# writes
W 00 a5a50001
W 01 5a5a0002
W 02 deadbeef
W 03 01234567
W 10 89abcdef
W 20 c0ffee00
W 3f 13579bdf
W 40 2468ace0
W 7f 0f0f0f0f
W 80 f0f0f0f0
W fe 11223344
W ff 55667788
W 02 cafef00d
# reads
R 0 00 a5a50001
R 1 01 5a5a0002
R 0 02 cafef00d
R 1 03 01234567
R 1 10 89abcdef
R 0 20 c0ffee00
R 0 3f 13579bdf
R 1 40 2468ace0
R 0 7f 0f0f0f0f
R 1 80 f0f0f0f0
R 0 fe 11223344
R 1 ff 55667788
R 1 00 a5a50001
R 0 01 5a5a0002
R 1 02 cafef00d
R 0 10 89abcdef

//--- mem_rd_subsys.f
verilog/mem_pkg.sv
verilog/mux_pkg.sv
verilog/mem_rd_intf.sv
verilog/fifo_ctxt.sv
verilog/mem_rd_mux.sv
verilog/mem_rd_sram.sv
verilog/mem_rd_subsys.sv
testbench/mem_rd_subsys_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the shared read subsystem testbench with Verilator and run it.
# The exit status is nonzero when the build fails or the log reports a failure.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module mem_rd_subsys_tb \
    -f mem_rd_subsys.f \
    -o mem_rd_subsys_sim

./obj_dir/mem_rd_subsys_sim 2>&1 | tee "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
echo "simulation passed"

//--- testbench/mem_rd_subsys_tb.sv
/* testbench for the shared read subsystem: replays the cases file and
   checks routing, latency and data of every read */

`timescale 1ns/1ns

module mem_rd_subsys_tb;

    localparam int CLK_PERIOD = 100;
    localparam int LATENCY    = 2;
    localparam int WAIT_LIMIT = 20;
    localparam int NC         = mux_pkg::N_CTRL;

    logic           clk;
    logic           rst;
    mux_pkg::sel_t  sel;
    logic [NC-1:0]  req;
    mem_pkg::addr_t addr [NC];
    logic [NC-1:0]  rdy;
    logic [NC-1:0]  ack;
    mem_pkg::data_t rd_data;
    logic           wr_en;
    mem_pkg::addr_t wr_addr;
    mem_pkg::data_t wr_data;

    int          cyc;
    int          errors;
    int          n_pass;
    int          n_fail;
    logic        checking;
    logic [31:0] lcg_state;

    // reference copy of the RAM contents
    mem_pkg::data_t model [mem_pkg::MEM_DEPTH];

    mem_pkg::data_t pend_exp [NC];
    logic [NC-1:0]  accepted;
    int             accept_cnt [NC];
    int             ack_cnt [NC];

    // reads accepted and still waiting for their ack in the order they were accepted
    int             q_ctrl [$];
    int             q_edge [$];
    mem_pkg::data_t q_exp [$];

    mem_pkg::addr_t w_addr [$];
    mem_pkg::data_t w_data [$];
    int             r_ctrl [$];
    mem_pkg::addr_t r_addr [$];
    mem_pkg::data_t r_exp [$];

    mem_rd_subsys mem_rd_subsys_i (
        .clk     (clk),
        .rst     (rst),
        .sel     (sel),
        .req     (req),
        .addr    (addr),
        .rdy     (rdy),
        .ack     (ack),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    // cyc counts rising edges, so at a falling edge it names the last one
    initial begin
        clk = 1'b0;
        cyc = 0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
            if (clk) begin
                cyc++;
            end
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ======================================================================
    // cycle monitor
    // ======================================================================

    // inputs are still the ones the last rising edge saw, so rdy here is
    // the value that decided acceptance at that edge
    task automatic step_cycle();
        logic [NC-1:0] rdy_exp;
        logic [NC-1:0] ack_exp;
        int            lat;
        @(negedge clk);
        accepted = '0;
        if (checking) begin
            for (int i = 0; i < NC; i++) begin
                rdy_exp[i] = !wr_en && (int'(sel) == i);
            end
            assert (rdy === rdy_exp) else begin
                $display("mismatch rdy: got %h expected %h", rdy, rdy_exp);
                errors++;
            end
            if (ack !== '0) begin
                for (int i = 0; i < NC; i++) begin
                    if (ack[i]) begin
                        ack_cnt[i]++;
                    end
                end
                assert (q_ctrl.size() > 0) else begin
                    $display("ack %h arrived with no read outstanding", ack);
                    errors++;
                end
                if (q_ctrl.size() > 0) begin
                    ack_exp = '0;
                    ack_exp[q_ctrl[0]] = 1'b1;
                    lat = cyc + 1 - q_edge[0];
                    assert (ack === ack_exp) else begin
                        $display("mismatch ack: got %h expected %h", ack, ack_exp);
                        errors++;
                    end
                    assert (rd_data === q_exp[0]) else begin
                        $display("mismatch rd_data: got %h expected %h", rd_data, q_exp[0]);
                        errors++;
                    end
                    assert (lat == LATENCY) else begin
                        $display("read accepted at edge %0d was acked %0d cycles later",
                                 q_edge[0], lat);
                        errors++;
                    end
                    void'(q_ctrl.pop_front());
                    void'(q_edge.pop_front());
                    void'(q_exp.pop_front());
                end
            end else if (q_ctrl.size() > 0) begin
                assert (cyc + 1 - q_edge[0] < LATENCY) else begin
                    $display("no ack for the read on controller %0d accepted at edge %0d",
                             q_ctrl[0], q_edge[0]);
                    errors++;
                    void'(q_ctrl.pop_front());
                    void'(q_edge.pop_front());
                    void'(q_exp.pop_front());
                end
            end
            for (int i = 0; i < NC; i++) begin
                if (req[i] && rdy[i]) begin
                    accepted[i] = 1'b1;
                    accept_cnt[i]++;
                    q_ctrl.push_back(i);
                    q_edge.push_back(cyc);
                    q_exp.push_back(pend_exp[i]);
                end
            end
        end
    endtask

    // ======================================================================
    // stimulus helpers
    // ======================================================================

    task automatic wait_accept(input int ctrl);
        int n;
        step_cycle();
        n = 1;
        while (!accepted[ctrl] && n < WAIT_LIMIT) begin
            step_cycle();
            n++;
        end
        assert (accepted[ctrl]) else begin
            $display("timeout waiting for rdy on controller %0d", ctrl);
            errors++;
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (q_ctrl.size() > 0 && n < WAIT_LIMIT) begin
            step_cycle();
            n++;
        end
        assert (q_ctrl.size() == 0) else begin
            $display("timeout waiting for ack, %0d reads outstanding", q_ctrl.size());
            errors++;
            q_ctrl.delete();
            q_edge.delete();
            q_exp.delete();
        end
    endtask

    task automatic write_word(input mem_pkg::addr_t a, input mem_pkg::data_t d);
        wr_en   = 1'b1;
        wr_addr = a;
        wr_data = d;
        model[a] = d;
        step_cycle();
        wr_en = 1'b0;
    endtask

    task automatic start_read(input int ctrl, input mem_pkg::addr_t a,
                              input mem_pkg::data_t exp);
        sel            = mux_pkg::sel_t'(ctrl);
        req            = '0;
        req[ctrl]      = 1'b1;
        addr[ctrl]     = a;
        pend_exp[ctrl] = exp;
    endtask

    task automatic read_blocking(input int ctrl, input mem_pkg::addr_t a,
                                 input mem_pkg::data_t exp);
        start_read(ctrl, a, exp);
        wait_accept(ctrl);
        req = '0;
        wait_drained();
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %s: ok", name);
            n_pass++;
        end else begin
            $display("test %s: failed with %0d errors", name, errors - err_before);
            n_fail++;
        end
    endtask

    task automatic load_cases(output logic ok);
        int             fd;
        int             n;
        logic           done;
        logic [7:0]     tok;
        logic [959:0]   junk;
        int             c;
        mem_pkg::addr_t a;
        mem_pkg::data_t d;
        ok = 1'b0;
        fd = $fopen("testbench/mem_rd_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/mem_rd_cases.txt");
            errors++;
        end else begin
            done = 1'b0;
            while (!done) begin
                n = $fscanf(fd, "%s", tok);
                if (n != 1) begin
                    done = 1'b1;
                end else if (tok == "#") begin
                    n = $fgets(junk, fd);
                end else if (tok == "W") begin
                    n = $fscanf(fd, "%h %h", a, d);
                    w_addr.push_back(a);
                    w_data.push_back(d);
                end else if (tok == "R") begin
                    n = $fscanf(fd, "%d %h %h", c, a, d);
                    r_ctrl.push_back(c);
                    r_addr.push_back(a);
                    r_exp.push_back(d);
                end else begin
                    $display("unknown record type in the cases file");
                    errors++;
                    done = 1'b1;
                end
            end
            $fclose(fd);
            ok = (r_addr.size() >= 3);
            if (!ok) begin
                $display("the cases file holds too few read records");
                errors++;
            end
        end
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================

    initial begin
        logic           loaded;
        int             e0;
        int             a0;
        int             k0;
        int             ctrl;
        logic [31:0]    r;
        mem_pkg::data_t new_word;
        rst       = 1'b1;
        sel       = '0;
        req       = '0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        checking  = 1'b0;
        errors    = 0;
        n_pass    = 0;
        n_fail    = 0;
        lcg_state = 32'h9d26;
        for (int i = 0; i < NC; i++) begin
            addr[i]       = '0;
            pend_exp[i]   = '0;
            accept_cnt[i] = 0;
            ack_cnt[i]    = 0;
        end
        load_cases(loaded);
        repeat (3) step_cycle();
        rst      = 1'b0;
        checking = 1'b1;

        if (loaded) begin
            e0 = errors;
            for (int k = 0; k < 4; k++) begin
                sel = mux_pkg::sel_t'(k % 2);
                step_cycle();
                assert (ack === '0) else begin
                    $display("mismatch ack: got %h expected %h", ack, 2'b00);
                    errors++;
                end
            end
            report_test("reset_idle", e0);

            e0 = errors;
            foreach (w_addr[k]) begin
                write_word(w_addr[k], w_data[k]);
            end
            foreach (r_addr[k]) begin
                r = lcg_next();
                repeat (int'(r % 32'd3)) step_cycle();
                read_blocking(r_ctrl[k], r_addr[k], r_exp[k]);
            end
            report_test("write_readback", e0);

            // the first ack comes back while sel already points at controller 1
            e0 = errors;
            a0 = ack_cnt[0];
            k0 = ack_cnt[1];
            start_read(0, r_addr[0], model[r_addr[0]]);
            wait_accept(0);
            start_read(1, r_addr[1], model[r_addr[1]]);
            wait_accept(1);
            req = '0;
            wait_drained();
            assert (ack_cnt[0] == a0 + 1 && ack_cnt[1] == k0 + 1) else begin
                $display("each controller should see exactly one ack after a select change");
                errors++;
            end
            report_test("select_change", e0);

            e0 = errors;
            a0 = accept_cnt[1];
            k0 = ack_cnt[1];
            sel         = '0;
            req         = 2'b10;
            addr[1]     = r_addr[2];
            pend_exp[1] = model[r_addr[2]];
            repeat (5) step_cycle();
            req = '0;
            assert (accept_cnt[1] == a0 && ack_cnt[1] == k0) else begin
                $display("controller 1 was served while it was not selected");
                errors++;
            end
            report_test("unselected_ctrl", e0);

            e0 = errors;
            new_word = lcg_next();
            start_read(0, r_addr[0], new_word);
            wr_en   = 1'b1;
            wr_addr = r_addr[0];
            wr_data = new_word;
            model[r_addr[0]] = new_word;
            repeat (2) begin
                step_cycle();
                assert (!accepted[0]) else begin
                    $display("read accepted while a write was in progress");
                    errors++;
                end
            end
            wr_en = 1'b0;
            wait_accept(0);
            req = '0;
            wait_drained();
            report_test("write_backpressure", e0);

            // the low bit of the generator only alternates, so a middle bit picks
            e0 = errors;
            foreach (r_addr[k]) begin
                r = lcg_next();
                ctrl = int'(r[16]);
                start_read(ctrl, r_addr[k], model[r_addr[k]]);
                step_cycle();
                assert (accepted[ctrl]) else begin
                    $display("back-to-back read on controller %0d was not accepted", ctrl);
                    errors++;
                end
            end
            req = '0;
            wait_drained();
            report_test("back_to_back", e0);
        end

        $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errors);
        if (errors == 0 && n_fail == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : mem_rd_subsys_tb

//--- verilog/mem_rd_subsys.sv
/* shared read subsystem: two read controllers reach one RAM through the
   select-driven request mux */

`timescale 1ns/1ns

module mem_rd_subsys (
    input  logic                       clk,
    input  logic                       rst,
    input  mux_pkg::sel_t              sel,
    input  logic [mux_pkg::N_CTRL-1:0] req,
    input  mem_pkg::addr_t             addr [mux_pkg::N_CTRL],
    output logic [mux_pkg::N_CTRL-1:0] rdy,
    output logic [mux_pkg::N_CTRL-1:0] ack,
    output mem_pkg::data_t             rd_data,
    input  logic                       wr_en,
    input  mem_pkg::addr_t             wr_addr,
    input  mem_pkg::data_t             wr_data
);
    // ======================================================================
    // read port bundles
    // ======================================================================

    // one port per controller, plus the single port into the RAM
    mem_rd_intf ctrl_if [mux_pkg::N_CTRL] (.clk(clk));
    mem_rd_intf ram_if (.clk(clk));

    for (genvar g = 0; g < mux_pkg::N_CTRL; g++) begin : g_ctrl_port
        assign ctrl_if[g].req  = req[g];
        assign ctrl_if[g].addr = addr[g];

        assign rdy[g] = ctrl_if[g].rdy;
        assign ack[g] = ctrl_if[g].ack;
    end : g_ctrl_port

    // data is broadcast by the mux so any controller port gives the same word
    assign rd_data = ctrl_if[0].data;

    // ======================================================================
    // request mux and response routing
    // ======================================================================

    mem_rd_mux mem_rd_mux_i (
        .from_controller (ctrl_if),
        .to_peripheral   (ram_if),
        .sel             (sel),
        .rst             (rst)
    );

    // ======================================================================
    // RAM
    // ======================================================================

    mem_rd_sram mem_rd_sram_i (
        .rst     (rst),
        .rd_port (ram_if),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

endmodule : mem_rd_subsys

//--- verilog/mem_rd_sram.sv
/* on-chip RAM with a fixed-latency pipelined read port and a plain write
   port that wins over a read in the same cycle */

`timescale 1ns/1ns

module mem_rd_sram (
    input  logic           rst,
    mem_rd_intf.peripheral rd_port,
    input  logic           wr_en,
    input  mem_pkg::addr_t wr_addr,
    input  mem_pkg::data_t wr_data
);
    logic clk;

    mem_pkg::data_t mem [mem_pkg::MEM_DEPTH];

    logic accept;

    // index 0 is stage one, the last index drives the response
    logic [mem_pkg::RD_LATENCY-1:0] vld;
    mem_pkg::data_t                 dat [mem_pkg::RD_LATENCY];

    assign clk = rd_port.clk;

    // ======================================================================
    // write port
    // ======================================================================

    // a write holds off reads for the cycle, so a read accepted later
    // always sees the updated word
    assign rd_port.rdy = !wr_en;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ======================================================================
    // read pipeline
    // ======================================================================

    assign accept = rd_port.req && rd_port.rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else begin
            vld[0] <= accept;
            for (int i = 1; i < mem_pkg::RD_LATENCY; i++) begin
                vld[i] <= vld[i-1];
            end
        end
    end

    // stage one captures the array word, later stages just carry it along
    always_ff @(posedge clk) begin
        if (accept) begin
            dat[0] <= mem[rd_port.addr];
        end
        for (int i = 1; i < mem_pkg::RD_LATENCY; i++) begin
            dat[i] <= dat[i-1];
        end
    end

    // ======================================================================
    // response
    // ======================================================================

    assign rd_port.ack  = vld[mem_pkg::RD_LATENCY-1];
    assign rd_port.data = dat[mem_pkg::RD_LATENCY-1];

endmodule : mem_rd_sram

//--- verilog/mem_rd_mux.sv
/* read request mux: forwards the selected controller to the RAM and steers
   every ack back to the controller that issued the read */

`timescale 1ns/1ns

module mem_rd_mux (
    mem_rd_intf.peripheral from_controller [mux_pkg::N_CTRL],
    mem_rd_intf.controller to_peripheral,
    input  mux_pkg::sel_t  sel,
    input  logic           rst
);
    logic clk;

    logic           req  [mux_pkg::N_CTRL];
    mem_pkg::addr_t addr [mux_pkg::N_CTRL];

    logic [mux_pkg::N_CTRL-1:0] rdy;
    logic [mux_pkg::N_CTRL-1:0] ack;

    logic          accept;
    mux_pkg::sel_t sel_head;

    assign clk = to_peripheral.clk;

    // ======================================================================
    // per-controller unpacking
    // ======================================================================

    // interface arrays cannot be indexed by a signal, so flatten them here
    for (genvar g = 0; g < mux_pkg::N_CTRL; g++) begin : g_ctrl
        assign req[g]  = from_controller[g].req;
        assign addr[g] = from_controller[g].addr;

        assign from_controller[g].rdy  = rdy[g];
        assign from_controller[g].ack  = ack[g];
        // read data is shared, only ack tells a controller it is theirs
        assign from_controller[g].data = to_peripheral.data;
    end : g_ctrl

    // ======================================================================
    // request mux
    // ======================================================================

    assign to_peripheral.req  = req[sel];
    assign to_peripheral.addr = addr[sel];

    // an unselected controller never sees rdy and so never gets accepted
    always_comb begin
        for (int i = 0; i < mux_pkg::N_CTRL; i++) begin
            rdy[i] = to_peripheral.rdy && (sel == mux_pkg::sel_t'(i));
        end
    end

    assign accept = to_peripheral.req && to_peripheral.rdy;

    // ======================================================================
    // context tracking
    // ======================================================================

    // sel may change while reads are still in the RAM pipeline, so the
    // owner of each read is queued at acceptance and retired with its ack
    fifo_ctxt fifo_ctxt_i (
        .clk     (clk),
        .rst     (rst),
        .wr      (accept),
        .wr_data (sel),
        .rd      (to_peripheral.ack),
        .rd_data (sel_head)
    );

    // ======================================================================
    // response demux
    // ======================================================================

    always_comb begin
        for (int i = 0; i < mux_pkg::N_CTRL; i++) begin
            ack[i] = to_peripheral.ack && (sel_head == mux_pkg::sel_t'(i));
        end
    end

endmodule : mem_rd_mux

//--- verilog/fifo_ctxt.sv
/* context FIFO: circular buffer holding the select value of each read
   that is still in flight */

`timescale 1ns/1ns

module fifo_ctxt (
    input  logic          clk,
    input  logic          rst,
    input  logic          wr,
    input  mux_pkg::sel_t wr_data,
    input  logic          rd,
    output mux_pkg::sel_t rd_data
);
    // ======================================================================
    // storage and pointers
    // ======================================================================

    mux_pkg::sel_t mem [mux_pkg::NUM_TRANSACTIONS];

    mux_pkg::ptr_t wr_ptr;
    mux_pkg::ptr_t rd_ptr;

    // one bit wider than a pointer so that a full buffer can be told apart
    logic [$bits(mux_pkg::ptr_t):0] count;

    logic push;
    logic pop;

    // guards only, the sizing in mux_pkg keeps these from ever blocking
    assign push = wr && ((count < mux_pkg::NUM_TRANSACTIONS) || rd);
    assign pop  = rd && (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // ======================================================================
    // pointer and occupancy control
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    // the head is always visible, a new entry shows up one cycle after its push
    assign rd_data = mem[rd_ptr];

endmodule : fifo_ctxt

//--- verilog/mem_rd_intf.sv
/* memory read port: req/rdy acceptance with a one-cycle ack carrying
   the read word */

`timescale 1ns/1ns

interface mem_rd_intf (
    input logic clk
);
    // request side, driven by the controller
    logic           req;
    mem_pkg::addr_t addr;

    // response side, driven by the peripheral
    logic           rdy;
    logic           ack;
    mem_pkg::data_t data;

    // a read is accepted in any cycle with req and rdy both high
    // and the controller keeps req and addr steady until then
    modport controller (
        input  clk,
        output req,
        output addr,
        input  rdy,
        input  ack,
        input  data
    );

    // ack is a single-cycle pulse with data valid alongside,
    // responses come back in the order they were accepted
    modport peripheral (
        input  clk,
        input  req,
        input  addr,
        output rdy,
        output ack,
        output data
    );

endinterface : mem_rd_intf

//--- verilog/mux_pkg.sv
/* mux package: controller count, select width and context FIFO sizing
   for the shared read path */

package mux_pkg;

    // ======================================================================
    // controllers
    // ======================================================================

    localparam int N_CTRL  = 2;
    localparam int SEL_WID = (N_CTRL > 1) ? $clog2(N_CTRL) : 1;

    typedef logic [SEL_WID-1:0] sel_t;

    // ======================================================================
    // context FIFO
    // ======================================================================

    // has to cover every read that can be in flight in the RAM pipeline,
    // so keep it at or above RD_LATENCY
    localparam int NUM_TRANSACTIONS = 4;

    typedef logic [$clog2(NUM_TRANSACTIONS)-1:0] ptr_t;

endpackage : mux_pkg

//--- verilog/mem_pkg.sv
/* memory package: address and data widths, word types and read timing
   of the on-chip RAM */

package mem_pkg;

    // ======================================================================
    // widths
    // ======================================================================

    localparam int ADDR_WID = 8;
    localparam int DATA_WID = 32;

    // one word per address, the array covers the whole address space
    localparam int MEM_DEPTH = 2 ** ADDR_WID;

    // ======================================================================
    // timing
    // ======================================================================

    // cycles from the accepting edge to the edge that samples ack
    localparam int RD_LATENCY = 2;

    // ======================================================================
    // types
    // ======================================================================

    typedef logic [ADDR_WID-1:0] addr_t;
    typedef logic [DATA_WID-1:0] data_t;

endpackage : mem_pkg
